//--- all.f
rtl/spi_link_pkg.sv
rtl/cfg_cmd_pkg.sv
rtl/spi_slave.sv
rtl/cfg_cmd_decoder.sv
rtl/cfg_reg_bank.sv
rtl/mcu_link_top.sv
dv/tb_mcu_link.sv

//--- dv/tb_mcu_link.sv
`timescale 1ns/10ps

module tb_mcu_link
  import spi_link_pkg::*;
  import cfg_cmd_pkg::*;
();

  // sck half-period and deselect gap in clk cycles
  localparam int HALF_CLKS = 8;
  localparam int GAP_CLKS  = 4;
  // longest message is a command plus four parameters
  localparam int MAX_BYTES = 5;
  // 2 unknown + write + read + counter + 30 random
  localparam int NUM_MSGS  = 35;
  localparam int MSG_CLKS  = MAX_BYTES * 8 * 2 * HALF_CLKS + HALF_CLKS + GAP_CLKS;
  localparam int CYCLE_LIMIT = NUM_MSGS * MSG_CLKS + 100;

  logic     clk;
  logic     rst;
  logic     sck;
  logic     mosi;
  logic     ssel_n;
  logic     miso;
  cfg_bus_t cfg;

  // shadow of the writable registers and the message counter
  cfg_bus_t    shadow_cfg;
  byte_t       shadow_cnt;
  logic [31:0] lfsr;
  string       test_name;
  int          checks;
  int          errors;
  int          cycles;

  mcu_link_top UUT (
    .clk    (clk),
    .rst    (rst),
    .sck    (sck),
    .mosi   (mosi),
    .ssel_n (ssel_n),
    .miso   (miso),
    .cfg    (cfg)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////
  // random source
  ////////////////////

  // taps 32 22 2 1 with the new bit entering at the bottom
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit with the msb taken first
  function automatic byte_t take_bits(input int n);
    byte_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[6:0], lfsr[0]};
    end
    return v;
  endfunction

  ////////////////////
  // reference model
  ////////////////////

  // top address reads the counter
  function automatic byte_t model_read(input reg_addr_t a);
    if (a == MSG_CNT_ADDR) begin
      return shadow_cnt;
    end
    return shadow_cfg[a];
  endfunction

  // reply byte k of a message
  // rd_addr sits at 0 until the first read parameter arrives
  // and then byte k carries register a+k-2
  function automatic byte_t expected_miso(input opcode_t op, input reg_addr_t a, input int k);
    if (op == OP_READ && k >= 2) begin
      return model_read(reg_addr_t'(int'(a) + k - 2));
    end
    return shadow_cfg[0];
  endfunction

  ////////////////////
  // checks
  ////////////////////

  task automatic check_byte(input string what, input int idx, input byte_t exp, input byte_t act);
    checks++;
    assert (act === exp) else begin
      $display("FAILED %s %s[%0d] expected %h actual %h", test_name, what, idx, exp, act);
      errors++;
    end
  endtask

  task automatic check_cfg();
    for (int i = 0; i < NUM_CFG_REGS; i++) begin
      check_byte("cfg", i, shadow_cfg[i], cfg[i]);
    end
  endtask

  task automatic finish_run();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  // hang guard
  always @(posedge clk) begin
    cycles++;
    if (cycles == CYCLE_LIMIT) begin
      $display("timeout, SPI traffic still running after %0d cycles", cycles);
      errors++;
      finish_run();
    end
  end

  ////////////////////
  // SPI master
  ////////////////////

  // mode 0 so mosi changes with the fall and miso is read just before the rise
  task automatic shift_byte(input byte_t out_b, output byte_t in_b);
    for (int i = 7; i >= 0; i--) begin
      mosi = out_b[i];
      repeat (HALF_CLKS) @(posedge clk);
      #1;
      in_b[i] = miso;
      sck = 1'b1;
      repeat (HALF_CLKS) @(posedge clk);
      #1;
      sck = 1'b0;
    end
  endtask

  // one whole message entered and left 1 ns after a clk rise
  task automatic run_message(input opcode_t op, input logic [3:0] low, input int nparam);
    byte_t     tx_byte;
    byte_t     rx_byte;
    byte_t     exp_q[$];
    byte_t     got_q[$];
    reg_addr_t a;
    reg_addr_t wa;
    a = low[2:0];
    ssel_n = 1'b0;
    for (int k = 0; k <= nparam; k++) begin
      if (k == 0) begin
        tx_byte = {op, low};
      end else begin
        tx_byte = take_bits(8);
      end
      exp_q.push_back(expected_miso(op, a, k));
      shift_byte(tx_byte, rx_byte);
      got_q.push_back(rx_byte);
      // write lands before the next reply byte is loaded
      if (op == OP_WRITE && k > 0) begin
        wa = reg_addr_t'(int'(a) + k - 1);
        if (wa != MSG_CNT_ADDR) begin
          shadow_cfg[wa] = tx_byte;
        end
      end
    end
    repeat (HALF_CLKS) @(posedge clk);
    #1;
    ssel_n = 1'b1;
    shadow_cnt++;
    repeat (GAP_CLKS) @(posedge clk);
    #1;
    for (int k = 0; k <= nparam; k++) begin
      check_byte("miso", k, exp_q[k], got_q[k]);
    end
    check_cfg();
  endtask

  ////////////////////
  // test sequence
  ////////////////////

  initial begin
    rst        = 1'b1;
    sck        = 1'b0;
    mosi       = 1'b0;
    ssel_n     = 1'b1;
    shadow_cfg = '0;
    shadow_cnt = '0;
    lfsr       = 32'h543b;
    checks     = 0;
    errors     = 0;
    cycles     = 0;

    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    test_name = "reset";
    check_cfg();
    check_byte("miso", 0, 8'h00, {7'b0, miso});

    // before any write so reg 0 and every reply byte are zero
    test_name = "unknown_op";
    run_message(4'd0, 4'd3, 3);
    run_message(4'd3, 4'd5, 3);

    // writes 5 and 6 then skips the counter slot and wraps to 0
    test_name = "write_incr";
    run_message(OP_WRITE, 4'd5, 4);

    // registers 5 and 6 come back, then the counter slot
    test_name = "read_back";
    run_message(OP_READ, 4'd5, 4);

    // four messages ended so far and then it wraps to reg 0
    test_name = "msg_counter";
    run_message(OP_READ, 4'd7, 3);

    test_name = "random_mix";
    for (int m = 0; m < 30; m++) begin
      run_message(opcode_t'(take_bits(2)), 4'(take_bits(4)), 1 + int'(take_bits(2)));
    end

    finish_run();
  end

endmodule

//--- rtl/cfg_cmd_decoder.sv
`timescale 1ns/10ps

module cfg_cmd_decoder
  import spi_link_pkg::*;
  import cfg_cmd_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  spi_rx_t   rx,
  input  spi_msg_t  msg,
  output reg_wr_t   wr,
  output reg_addr_t rd_addr
);

  dec_state_t state;

  // running register pointer for the current message
  reg_addr_t addr;

  // fields of the command byte, bit 3 is unused
  opcode_t   cmd_op;
  reg_addr_t cmd_addr;

  assign cmd_op   = rx.data[7:4];
  assign cmd_addr = rx.data[2:0];

  ////////////////////
  // message FSM
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= IDLE;
      addr    <= '0;
      rd_addr <= '0;
      wr      <= '0;
    end else begin
      // write strobe is single cycle
      wr.en <= 1'b0;

      if (msg.done) begin
        // message over, back to a clean start
        state   <= IDLE;
        addr    <= '0;
        rd_addr <= '0;
      end else if (rx.cmd) begin
        addr <= cmd_addr;
        case (cmd_op)
          OP_WRITE: state <= WRITE;
          OP_READ:  state <= READ;
          // unknown opcode, drop the rest of the message
          default:  state <= SKIP;
        endcase
      end else if (rx.param) begin
        case (state)
          WRITE: begin
            // counter slot is read only, pointer still moves on
            wr.en   <= (addr != MSG_CNT_ADDR);
            wr.addr <= addr;
            wr.data <= rx.data;
            addr    <= addr + 3'd1;
          end
          READ: begin
            // next reply byte, loaded at the coming byte boundary
            rd_addr <= addr;
            addr    <= addr + 3'd1;
          end
          default: begin
            // idle or skip, nothing to do
            addr <= addr;
          end
        endcase
      end
    end
  end

endmodule

//--- rtl/cfg_cmd_pkg.sv
package cfg_cmd_pkg;

  import spi_link_pkg::*;

  ////////////////////
  // register map
  ////////////////////

  // writable registers 0..6
  localparam int NUM_CFG_REGS = 7;

  typedef logic [2:0] reg_addr_t;

  // read-only message counter sits at the top address
  localparam reg_addr_t MSG_CNT_ADDR = 3'd7;

  // slot n is register n
  typedef byte_t [NUM_CFG_REGS-1:0] cfg_bus_t;

  // one register write
  typedef struct packed {
    logic      en;
    reg_addr_t addr;
    byte_t     data;
  } reg_wr_t;

  ////////////////////
  // command byte
  ////////////////////

  // upper nibble of the command byte
  typedef logic [3:0] opcode_t;

  localparam opcode_t OP_WRITE = 4'd1;
  localparam opcode_t OP_READ  = 4'd2;

  // decoder FSM
  typedef enum logic [1:0] {
    IDLE,
    WRITE,
    READ,
    SKIP
  } dec_state_t;

endpackage

//--- rtl/cfg_reg_bank.sv
`timescale 1ns/10ps

module cfg_reg_bank
  import spi_link_pkg::*;
  import cfg_cmd_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  reg_wr_t   wr,
  input  reg_addr_t rd_addr,
  input  logic      msg_done,
  output byte_t     rd_data,
  output cfg_bus_t  cfg
);

  cfg_bus_t regs;

  // ended messages, wraps at 256
  byte_t msg_cnt;

  ////////////////////
  // write port
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      regs    <= '0;
      msg_cnt <= '0;
    end else begin
      for (int i = 0; i < NUM_CFG_REGS; i++) begin
        if (wr.en && wr.addr == reg_addr_t'(i)) begin
          regs[i] <= wr.data;
        end
      end
      if (msg_done) begin
        msg_cnt <= msg_cnt + 8'd1;
      end
    end
  end

  ////////////////////
  // read port
  ////////////////////

  // combinational from rd_addr
  always_comb begin
    rd_data = '0;
    if (rd_addr == MSG_CNT_ADDR) begin
      rd_data = msg_cnt;
    end else begin
      for (int i = 0; i < NUM_CFG_REGS; i++) begin
        if (rd_addr == reg_addr_t'(i)) begin
          rd_data = regs[i];
        end
      end
    end
  end

  // writable registers straight out
  assign cfg = regs;

endmodule

//--- rtl/mcu_link_top.sv
`timescale 1ns/10ps

module mcu_link_top
  import spi_link_pkg::*;
  import cfg_cmd_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     sck,
  input  logic     mosi,
  input  logic     ssel_n,
  output logic     miso,
  output cfg_bus_t cfg
);

  // slave to decoder
  spi_rx_t  rx;
  spi_msg_t msg;

  // decoder to bank
  reg_wr_t   wr;
  reg_addr_t rd_addr;

  // bank back to slave, next reply byte
  byte_t rd_data;

  spi_slave u_spi_slave (
    .clk     (clk),
    .rst     (rst),
    .sck     (sck),
    .mosi    (mosi),
    .ssel_n  (ssel_n),
    .rd_data (rd_data),
    .miso    (miso),
    .rx      (rx),
    .msg     (msg)
  );

  cfg_cmd_decoder u_cfg_cmd_decoder (
    .clk     (clk),
    .rst     (rst),
    .rx      (rx),
    .msg     (msg),
    .wr      (wr),
    .rd_addr (rd_addr)
  );

  // counter advances on every message end, whatever the opcode
  cfg_reg_bank u_cfg_reg_bank (
    .clk      (clk),
    .rst      (rst),
    .wr       (wr),
    .rd_addr  (rd_addr),
    .msg_done (msg.done),
    .rd_data  (rd_data),
    .cfg      (cfg)
  );

endmodule

//--- rtl/spi_link_pkg.sv
package spi_link_pkg;

  // synchronizer depth on each pin
  localparam int SYNC_STAGES = 2;

  // one data byte on the link
  typedef logic [7:0] byte_t;

  // raw pin group, sampled together
  typedef struct packed {
    logic sck;
    logic ssel_n;
    logic mosi;
  } spi_pins_t;

  // pin levels when the bus is idle and deselected
  localparam spi_pins_t PINS_IDLE = '{sck: 1'b0, ssel_n: 1'b1, mosi: 1'b0};

  // received byte event, strobes last one cycle
  typedef struct packed {
    logic  cmd;
    logic  param;
    byte_t data;
  } spi_rx_t;

  // message boundary pulses
  typedef struct packed {
    logic start;
    logic done;
  } spi_msg_t;

endpackage

//--- rtl/spi_slave.sv
`timescale 1ns/10ps

module spi_slave
  import spi_link_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     sck,
  input  logic     mosi,
  input  logic     ssel_n,
  input  byte_t    rd_data,
  output logic     miso,
  output spi_rx_t  rx,
  output spi_msg_t msg
);

  // stage 0 is the newest sample, stage SYNC_STAGES the previous synced value
  spi_pins_t [SYNC_STAGES:0] pin_sh;
  spi_pins_t                 pins_in;
  spi_pins_t                 pins_s;

  logic       sck_rise;
  logic       sck_fall;
  logic [2:0] bit_cnt;
  logic       first_byte;
  byte_t      rx_sh;
  byte_t      rx_next;
  byte_t      tx_sh;

  ////////////////////
  // pin synchronizers
  ////////////////////

  assign pins_in = {sck, ssel_n, mosi};

  // synced levels, aligned with the registered edge flags
  assign pins_s = pin_sh[SYNC_STAGES];

  // edge flags registered, so pin to flag is SYNC_STAGES+1 clk
  always_ff @(posedge clk) begin
    if (rst) begin
      // idle pattern, so no false select edge after reset
      pin_sh   <= {(SYNC_STAGES+1){PINS_IDLE}};
      sck_rise <= 1'b0;
      sck_fall <= 1'b0;
      msg      <= '0;
    end else begin
      pin_sh   <= {pin_sh[SYNC_STAGES-1:0], pins_in};
      sck_rise <= pin_sh[SYNC_STAGES-1].sck & ~pin_sh[SYNC_STAGES].sck;
      sck_fall <= ~pin_sh[SYNC_STAGES-1].sck & pin_sh[SYNC_STAGES].sck;
      // select is active low
      msg.start <= ~pin_sh[SYNC_STAGES-1].ssel_n & pin_sh[SYNC_STAGES].ssel_n;
      msg.done  <= pin_sh[SYNC_STAGES-1].ssel_n & ~pin_sh[SYNC_STAGES].ssel_n;
    end
  end

  ////////////////////
  // receive side
  ////////////////////

  // msb first, new bit enters at the bottom
  assign rx_next = {rx_sh[6:0], pins_s.mosi};

  always_ff @(posedge clk) begin
    if (!pins_s.ssel_n && sck_rise) begin
      rx_sh <= rx_next;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      bit_cnt    <= 3'd0;
      first_byte <= 1'b1;
      rx         <= '0;
    end else begin
      // strobes only last one cycle
      rx.cmd   <= 1'b0;
      rx.param <= 1'b0;
      if (pins_s.ssel_n) begin
        // deselected, rearm for the next command byte
        bit_cnt    <= 3'd0;
        first_byte <= 1'b1;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
        if (bit_cnt == 3'd7) begin
          // eighth bit in, byte complete
          rx.cmd     <= first_byte;
          rx.param   <= ~first_byte;
          rx.data    <= rx_next;
          first_byte <= 1'b0;
        end
      end
    end
  end

  ////////////////////
  // transmit side
  ////////////////////

  // mode 0, master samples on rise so we change on fall
  always_ff @(posedge clk) begin
    if (rst) begin
      tx_sh <= '0;
    end else if (msg.start) begin
      // first reply byte ready before the first rise
      tx_sh <= rd_data;
    end else if (sck_fall) begin
      if (bit_cnt == 3'd0) begin
        // byte boundary, take the next reply byte
        tx_sh <= rd_data;
      end else begin
        tx_sh <= {tx_sh[6:0], 1'b0};
      end
    end
  end

  // msb out first
  assign miso = tx_sh[7];

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the mcu link testbench with verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 --top-module tb_mcu_link -f all.f -o sim_tb; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "Test completed successfully"; then
  exit 0
fi
echo "pass message not found"
exit 1
